// ==== bench/cpuCoreTb.sv ====
`timescale 1ns/100ps

module cpuCoreTb import cpuPkg::*, isaPkg::*; ();

	localparam int romDepth = 512;
	localparam int runLimit = 4000;

	logic CLK, rstN;
	logic [instWidth-1:0] inst;
	logic [dataWidth-1:0] memReadData, pc, memAddr, memWriteData;
	logic memWrite;
	logic [4:0] flags;
	logic [instWidth-1:0] rom [romDepth];
	logic [dataWidth-1:0] ram [65536];
	// program under construction and the RAM words it must leave behind
	logic [instWidth-1:0] prog [$];
	logic [dataWidth-1:0] expAddr [$];
	logic [dataWidth-1:0] expVal [$];
	logic [31:0] rngState;
	int errorCount, checkCount;

	cpuCore u_dut (.CLK(CLK), .rstN(rstN), .inst(inst), .memReadData(memReadData), .pc(pc),
		.memAddr(memAddr), .memWriteData(memWriteData), .memWrite(memWrite), .flags(flags));

	//////////////////////////////////////////////////
	// clock and memory models
	//////////////////////////////////////////////////

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// both memories answer in zero time
	assign inst = rom[pc[8:0]];
	assign memReadData = ram[memAddr];

	// writes are ignored during reset so reloading the program is safe
	always @(posedge CLK) begin
		if (rstN && memWrite)
			ram[memAddr] <= memWriteData;
	end

	// a write strobe towards the I/O region must never appear
	always @(negedge CLK) begin
		if (rstN) begin
			assert (!(memWrite && memAddr[ioRegionBit])) else begin
				errorCount++;
				$display("memWrite went high for the I/O address %h", memAddr);
			end
		end
	end

	//////////////////////////////////////////////////
	// instruction encoding and reference model
	//////////////////////////////////////////////////

	function automatic logic [instWidth-1:0] regOp(input logic [5:0] op, input logic [3:0] d,
			input logic [3:0] a, input logic [3:0] b);
		return {op, d, a, b};
	endfunction

	function automatic logic [instWidth-1:0] immOp(input logic [5:0] op, input logic [3:0] d,
			input logic [7:0] imm);
		return {op, d, imm};
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// initial RAM content, different for every address
	function automatic logic [15:0] fillWord(input logic [15:0] addr);
		return addr ^ 16'h5AC3;
	endfunction

	// returns the flag word above the 16 bit result of an add or a subtract
	function automatic logic [20:0] refArith(input logic [15:0] a, input logic [15:0] b,
			input logic cin, input logic isSub);
		logic [16:0] s;
		logic [4:0] f;
		f = '0;
		if (isSub) begin
			s = {1'b0, a} - {1'b0, b};
			f[flagLow] = (a < b);
			f[flagCarry] = (a >= b);
			f[flagOverflow] = (a[15] != b[15]) && (s[15] != a[15]);
		end else begin
			s = {1'b0, a} + {1'b0, b} + {16'h0000, cin};
			f[flagCarry] = s[16];
			f[flagOverflow] = (a[15] == b[15]) && (s[15] != a[15]);
		end
		f[flagZero] = (s[15:0] == '0);
		f[flagNeg] = s[15];
		return {f, s[15:0]};
	endfunction

	//////////////////////////////////////////////////
	// program building, running and checking
	//////////////////////////////////////////////////

	task automatic newProgram();
		prog.delete();
		expAddr.delete();
		expVal.delete();
	endtask

	task automatic emit(input logic [instWidth-1:0] i);
		prog.push_back(i);
	endtask

	task automatic expectWord(input logic [15:0] addr, input logic [15:0] val);
		expAddr.push_back(addr);
		expVal.push_back(val);
	endtask

	// r15 carries the address, so programs keep it free around a store
	task automatic storeAt(input logic [7:0] addr, input logic [3:0] r);
		emit(immOp(opMovi, 4'd15, addr));
		emit(regOp(opStor, 4'd0, 4'd15, r));
	endtask

	// builds a full 16 bit constant, r12 must already hold 8
	task automatic loadConst(input logic [3:0] r, input logic [15:0] val);
		emit(immOp(opMovi, r, val[15:8]));
		emit(regOp(opLsh, r, r, 4'd12));
		emit(immOp(opAddi, r, val[7:0]));
	endtask

	// the ROM is swapped while the core sits in reset, the tail is a jump onto itself
	task automatic startProgram();
		@(posedge CLK);
		rstN <= 1'b0;
		@(posedge CLK);
		for (int i = 0; i < romDepth; i++)
			rom[9'(i)] = (i < prog.size()) ? prog[i] : immOp(opJcond, condAlways, 8'h00);
		for (int i = 0; i < 65536; i++)
			ram[16'(i)] = fillWord(16'(i));
		@(posedge CLK);
		rstN <= 1'b1;
		// first fetch after release
		@(negedge CLK);
		checkCount += 2;
		assert (pc == '0) else begin
			errorCount++;
			$display("** Error pc = %h, expected %h", pc, 16'h0000);
		end
		assert (memWrite == 1'b0) else begin
			errorCount++;
			$display("** Error memWrite = %h, expected %h", memWrite, 1'b0);
		end
	endtask

	// everything before the target address has completed once pc shows it
	task automatic runTo(input logic [15:0] target);
		int cycles;
		cycles = 0;
		while (pc != target && cycles < runLimit) begin
			@(negedge CLK);
			cycles++;
		end
		if (pc != target) begin
			errorCount++;
			$display("pc did not reach %h within %0d cycles", target, runLimit);
		end
	endtask

	task automatic checkFlags(input logic [4:0] exp);
		checkCount++;
		assert (flags == exp) else begin
			errorCount++;
			$display("** Error flags = %h, expected %h", flags, exp);
		end
	endtask

	task automatic checkRam();
		foreach (expAddr[k]) begin
			checkCount++;
			assert (ram[expAddr[k]] == expVal[k]) else begin
				errorCount++;
				$display("** Error ram[%h] = %h, expected %h", expAddr[k], ram[expAddr[k]],
					expVal[k]);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic aluTest();
		logic [15:0] a, b;
		a = 16'h005C;
		b = 16'h0037;
		newProgram();
		emit(immOp(opMovi, 4'd1, a[7:0]));
		emit(immOp(opMovi, 4'd2, b[7:0]));
		emit(regOp(opAdd, 4'd3, 4'd1, 4'd2));
		emit(regOp(opSub, 4'd4, 4'd1, 4'd2));
		emit(regOp(opAnd, 4'd5, 4'd1, 4'd2));
		emit(regOp(opOr, 4'd6, 4'd1, 4'd2));
		emit(regOp(opXor, 4'd7, 4'd1, 4'd2));
		emit(regOp(opLsh, 4'd8, 4'd1, 4'd2));
		for (int r = 1; r <= 8; r++)
			storeAt(8'h10 + 8'(r), 4'(r));
		expectWord(16'h0011, a);
		expectWord(16'h0012, b);
		expectWord(16'h0013, a + b);
		expectWord(16'h0014, a - b);
		expectWord(16'h0015, a & b);
		expectWord(16'h0016, a | b);
		expectWord(16'h0017, a ^ b);
		// shift amount is the low four bits of srcB
		expectWord(16'h0018, a << b[3:0]);
		startProgram();
		runTo(16'(prog.size()));
		checkRam();
	endtask

	task automatic flagTest();
		logic [20:0] addModel, addcModel, eqModel, loModel;
		addModel = refArith(16'hFFFF, 16'h0002, 1'b0, 1'b0);
		addcModel = refArith(16'h0005, 16'h0007, addModel[16 + flagCarry], 1'b0);
		eqModel = refArith(16'h0005, 16'h0005, 1'b0, 1'b1);
		loModel = refArith(16'h0005, 16'h0007, 1'b0, 1'b1);
		newProgram();
		// r1 becomes 0xFFFF so adding 2 carries out
		emit(immOp(opMovi, 4'd1, 8'hFF));
		emit(immOp(opMovi, 4'd2, 8'h08));
		emit(regOp(opLsh, 4'd1, 4'd1, 4'd2));
		emit(immOp(opAddi, 4'd1, 8'hFF));
		emit(immOp(opMovi, 4'd2, 8'h02));
		emit(regOp(opAdd, 4'd3, 4'd1, 4'd2));
		emit(immOp(opMovi, 4'd4, 8'h05));
		emit(immOp(opMovi, 4'd5, 8'h07));
		emit(regOp(opAddc, 4'd6, 4'd4, 4'd5));
		storeAt(8'h20, 4'd6);
		storeAt(8'h21, 4'd3);
		emit(regOp(opCmp, 4'd0, 4'd4, 4'd4));
		emit(regOp(opCmp, 4'd0, 4'd4, 4'd5));
		expectWord(16'h0020, addcModel[15:0]);
		expectWord(16'h0021, addModel[15:0]);
		startProgram();
		runTo(16'd6);
		checkFlags(addModel[20:16]);
		runTo(16'd13);
		checkFlags(addcModel[20:16]);
		runTo(16'd14);
		checkFlags(eqModel[20:16]);
		runTo(16'd15);
		checkFlags(loModel[20:16]);
		checkRam();
	endtask

	task automatic memTest();
		newProgram();
		emit(immOp(opMovi, 4'd1, 8'h3C));
		storeAt(8'h30, 4'd1);
		// r15 still points at 0x30
		emit(regOp(opLoad, 4'd2, 4'd15, 4'd0));
		storeAt(8'h31, 4'd2);
		// 0x8000 and 0xC000 are built by shifting
		emit(immOp(opMovi, 4'd13, 8'h01));
		emit(immOp(opMovi, 4'd12, 8'h0F));
		emit(regOp(opLsh, 4'd13, 4'd13, 4'd12));
		emit(regOp(opStor, 4'd0, 4'd13, 4'd1));
		emit(immOp(opMovi, 4'd11, 8'h03));
		emit(immOp(opMovi, 4'd12, 8'h0E));
		emit(regOp(opLsh, 4'd11, 4'd11, 4'd12));
		emit(regOp(opStor, 4'd0, 4'd11, 4'd1));
		expectWord(16'h0030, 16'h003C);
		expectWord(16'h0031, 16'h003C);
		expectWord(16'h8000, fillWord(16'h8000));
		expectWord(16'hC000, fillWord(16'hC000));
		startProgram();
		runTo(16'(prog.size()));
		checkRam();
	endtask

	task automatic jumpTest();
		newProgram();
		emit(immOp(opMovi, 4'd1, 8'h04));
		emit(immOp(opMovi, 4'd15, 8'h40));
		emit(immOp(opMovi, 4'd14, 8'h41));
		emit(regOp(opCmp, 4'd0, 4'd1, 4'd1));
		// taken, the store at 5 is skipped
		emit(immOp(opJcond, condEq, 8'd2));
		emit(regOp(opStor, 4'd0, 4'd15, 4'd1));
		// zero is still set so this falls through to the store at 7
		emit(immOp(opJcond, condNe, 8'd2));
		emit(regOp(opStor, 4'd0, 4'd14, 4'd1));
		// r3 counts the passes while r1 runs down to zero
		emit(immOp(opMovi, 4'd3, 8'h00));
		emit(immOp(opAddi, 4'd3, 8'h01));
		emit(immOp(opSubi, 4'd1, 8'h01));
		emit(immOp(opJcond, condEq, 8'd2));
		emit(immOp(opJcond, condAlways, 8'hFD));
		storeAt(8'h42, 4'd1);
		storeAt(8'h43, 4'd3);
		expectWord(16'h0040, fillWord(16'h0040));
		expectWord(16'h0041, 16'h0004);
		expectWord(16'h0042, 16'h0000);
		expectWord(16'h0043, 16'h0004);
		startProgram();
		runTo(16'(prog.size()));
		checkRam();
	endtask

	task automatic randomTest();
		logic [15:0] a, b, base;
		logic [20:0] sumModel, diffModel;
		newProgram();
		emit(immOp(opMovi, 4'd12, 8'h08));
		emit(immOp(opMovi, 4'd15, 8'h80));
		for (int k = 0; k < 20; k++) begin
			rngState = xorshift(rngState);
			a = rngState[15:0];
			b = rngState[31:16];
			loadConst(4'd1, a);
			loadConst(4'd2, b);
			emit(regOp(opAdd, 4'd3, 4'd1, 4'd2));
			emit(regOp(opSub, 4'd4, 4'd1, 4'd2));
			emit(regOp(opXor, 4'd5, 4'd1, 4'd2));
			// r15 walks up one word per result
			for (int j = 3; j <= 5; j++) begin
				emit(regOp(opStor, 4'd0, 4'd15, 4'(j)));
				emit(immOp(opAddi, 4'd15, 8'h01));
			end
			sumModel = refArith(a, b, 1'b0, 1'b0);
			diffModel = refArith(a, b, 1'b0, 1'b1);
			base = 16'h0080 + 16'(3 * k);
			expectWord(base, sumModel[15:0]);
			expectWord(base + 16'd1, diffModel[15:0]);
			expectWord(base + 16'd2, a ^ b);
		end
		startProgram();
		runTo(16'(prog.size()));
		checkRam();
	endtask

	initial begin
		rstN = 1'b0;
		errorCount = 0;
		checkCount = 0;
		rngState = 32'd40;
		aluTest();
		flagTest();
		memTest();
		jumpTest();
		randomTest();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module cpuCoreTb -f verilog.f -o simv
out=$(./obj_dir/simv)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
else
	exit 1
fi

// ==== verilog.f ====
verilog/cpuPkg.sv
verilog/isaPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/progCounter.sv
verilog/instrDecoder.sv
verilog/instrFsm.sv
verilog/cpuCore.sv
bench/cpuCoreTb.sv

// ==== verilog/alu.sv ====
`timescale 1ns/100ps

module alu import cpuPkg::*, isaPkg::*; (
	input logic carryIn,
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input aluOp_e aluOp,
	output logic [dataWidth-1:0] result,
	output logic [4:0] flags
);

	// one adder serves add, addc and sub
	logic isSub;
	logic isArith;
	logic addCin;
	logic [dataWidth-1:0] addB;
	logic [dataWidth:0] sum;

	assign isSub = (aluOp == aluSub);
	assign isArith = isSub | (aluOp == aluAdd) | (aluOp == aluAddc);

	// subtraction is a plus the inverted b plus one
	assign addB = isSub ? ~b : b;
	assign addCin = isSub | ((aluOp == aluAddc) & carryIn);
	// the extra top bit of the sum is the carry out
	assign sum = {1'b0, a} + {1'b0, addB} + {{dataWidth{1'b0}}, addCin};

	//////////////////////////////////////////////////
	// result select
	//////////////////////////////////////////////////

	always_comb begin
		case (aluOp)
			aluAdd, aluAddc, aluSub: result = sum[dataWidth-1:0];
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			// only the low four bits of b count as the shift amount
			aluShiftLeft: result = a << b[3:0];
			aluPassB: result = b;
			default: result = b;
		endcase
	end

	//////////////////////////////////////////////////
	// flags
	//////////////////////////////////////////////////

	always_comb begin
		flags = '0;
		// for sub this is the not-borrow, for add the plain carry out
		flags[flagCarry] = isArith & sum[dataWidth];
		// a borrow happened when the inverted-b sum did not carry
		flags[flagLow] = isSub & ~sum[dataWidth];
		// same sign operands giving a result of the other sign
		flags[flagOverflow] = isArith & (a[dataWidth-1] == addB[dataWidth-1])
			& (sum[dataWidth-1] != a[dataWidth-1]);
		flags[flagZero] = (result == '0);
		flags[flagNeg] = result[dataWidth-1];
	end

endmodule

// ==== verilog/cpuCore.sv ====
`timescale 1ns/100ps

module cpuCore import cpuPkg::*, isaPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic [instWidth-1:0] inst,
	input logic [dataWidth-1:0] memReadData,
	output logic [dataWidth-1:0] pc,
	output logic [dataWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWriteData,
	output logic memWrite,
	output logic [4:0] flags
);

	instWord_u word;
	aluOp_e aluOp;
	logic [5:0] opcode;
	logic [3:0] readRegA, readRegB, loadReg;
	logic [dataWidth-1:0] imm, regA, regB, regM, operandB, aluResult, writeData;
	logic selectImm, selectResult, rawMemWrite, writesFlags;
	logic regLoad, memStrobe, pcInc, jumpSelect;
	logic [4:0] aluFlags;

	// the address register is always the srcA field, whatever the A operand mux picks
	assign word = inst;

	instrFsm fsm (.CLK(CLK), .rstN(rstN), .opcode(opcode), .cond(loadReg),
		.writesFlags(writesFlags), .aluFlags(aluFlags), .storedFlags(flags),
		.regLoad(regLoad), .memStrobe(memStrobe), .pcInc(pcInc), .jumpSelect(jumpSelect));

	progCounter pcReg (.CLK(CLK), .rstN(rstN), .pcInc(pcInc), .jumpSelect(jumpSelect),
		.offset(imm[7:0]), .pc(pc));

	instrDecoder decoder (.inst(inst), .opcode(opcode), .aluOp(aluOp), .imm(imm),
		.readRegA(readRegA), .readRegB(readRegB), .loadReg(loadReg), .selectImm(selectImm),
		.selectResult(selectResult), .rawMemWrite(rawMemWrite), .writesFlags(writesFlags));

	// add with carry picks up the carry of the last flag setting instruction
	alu aluUnit (.carryIn(flags[flagCarry]), .a(regA), .b(operandB), .aluOp(aluOp),
		.result(aluResult), .flags(aluFlags));

	regFile registers (.CLK(CLK), .rstN(rstN), .load(regLoad), .loadReg(loadReg),
		.writeData(writeData), .readRegA(readRegA), .readRegB(readRegB),
		.readRegM(word.regForm.srcA), .regA(regA), .regB(regB), .regM(regM));

	//////////////////////////////////////////////////
	// operand and write back muxes
	//////////////////////////////////////////////////

	assign operandB = selectImm ? imm : regB;
	assign writeData = selectResult ? memReadData : aluResult;

	// store data comes from srcB, address from srcA
	assign memAddr = regM;
	assign memWriteData = regB;

	// top bits 10 and 11 are I/O space, a store there is silently dropped
	assign memWrite = memStrobe & rawMemWrite & ~memAddr[ioRegionBit];

endmodule

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

	//////////////////////////////////////////////////
	// datapath geometry
	//////////////////////////////////////////////////

	// a data word and a data address share one width
	localparam int dataWidth = 16;
	// sixteen general registers, all of them writable
	localparam int regCount = 16;

	//////////////////////////////////////////////////
	// positions inside the five bit flag word
	//////////////////////////////////////////////////

	localparam int flagCarry = 4;
	// low is set when the subtraction borrowed, so a was below b unsigned
	localparam int flagLow = 3;
	localparam int flagOverflow = 2;
	localparam int flagZero = 1;
	localparam int flagNeg = 0;

	// addresses with this bit set are memory mapped I/O and never written
	localparam int ioRegionBit = 15;

endpackage

// ==== verilog/instrDecoder.sv ====
`timescale 1ns/100ps

module instrDecoder import cpuPkg::*, isaPkg::*; (
	input logic [instWidth-1:0] inst,
	output logic [5:0] opcode,
	output aluOp_e aluOp,
	output logic [dataWidth-1:0] imm,
	output logic [3:0] readRegA,
	output logic [3:0] readRegB,
	output logic [3:0] loadReg,
	output logic selectImm,
	output logic selectResult,
	output logic rawMemWrite,
	output logic writesFlags
);

	instWord_u word;

	assign word = inst;
	// opcode and dst sit at the same bits in both views
	assign opcode = word.regForm.opcode;
	// the destination doubles as the jump condition for jcond
	assign loadReg = word.regForm.dst;
	// always zero extended here, the PC does its own sign extension
	assign imm = {{(dataWidth-8){1'b0}}, word.immForm.imm};

	always_comb begin
		// an unknown opcode falls through as a pass with no side effects
		aluOp = aluPassB;
		readRegA = word.regForm.srcA;
		readRegB = word.regForm.srcB;
		selectImm = 1'b0;
		selectResult = 1'b0;
		rawMemWrite = 1'b0;
		writesFlags = 1'b0;
		case (opcode)
			opAdd: begin
				aluOp = aluAdd;
				writesFlags = 1'b1;
			end
			opAddc: begin
				aluOp = aluAddc;
				writesFlags = 1'b1;
			end
			opSub, opCmp: begin
				aluOp = aluSub;
				writesFlags = 1'b1;
			end
			opAnd: aluOp = aluAnd;
			opOr: aluOp = aluOr;
			opXor: aluOp = aluXor;
			opLsh: aluOp = aluShiftLeft;
			// immediate ops take their first operand from dst
			opAddi, opSubi: begin
				aluOp = (opcode == opAddi) ? aluAdd : aluSub;
				readRegA = word.immForm.dst;
				selectImm = 1'b1;
				writesFlags = 1'b1;
			end
			opMovi: selectImm = 1'b1;
			// write back comes from the data memory instead of the ALU
			opLoad: selectResult = 1'b1;
			opStor: rawMemWrite = 1'b1;
			default: aluOp = aluPassB;
		endcase
	end

endmodule

// ==== verilog/instrFsm.sv ====
`timescale 1ns/100ps

module instrFsm import cpuPkg::*, isaPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic [5:0] opcode,
	input logic [3:0] cond,
	input logic writesFlags,
	input logic [4:0] aluFlags,
	output logic [4:0] storedFlags,
	output logic regLoad,
	output logic memStrobe,
	output logic pcInc,
	output logic jumpSelect
);

	// low means fetch, high means execute
	logic inExecute;
	// set for every opcode that puts a value into a register
	logic writesReg;
	logic condMet;

	//////////////////////////////////////////////////
	// phase and flag register
	//////////////////////////////////////////////////

	// the two phases simply alternate, there is no stall of any kind
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			inExecute <= 1'b0;
			storedFlags <= '0;
		end else begin
			inExecute <= ~inExecute;
			// flags are captured on the same edge that writes the register
			if (inExecute && writesFlags)
				storedFlags <= aluFlags;
		end
	end

	// cmp, store, jump and unknown opcodes leave the register file alone
	always_comb begin
		case (opcode)
			opAdd, opAddc, opSub, opAnd, opOr, opXor, opLsh,
			opAddi, opSubi, opMovi, opLoad: writesReg = 1'b1;
			default: writesReg = 1'b0;
		endcase
	end

	// the condition looks at the flags of an earlier instruction, never the live ALU
	always_comb begin
		case (cond)
			condAlways: condMet = 1'b1;
			condEq: condMet = storedFlags[flagZero];
			condNe: condMet = ~storedFlags[flagZero];
			condLo: condMet = storedFlags[flagLow];
			default: condMet = 1'b0;
		endcase
	end

	// all strobes belong to the execute phase
	assign regLoad = inExecute & writesReg;
	assign memStrobe = inExecute;
	assign pcInc = inExecute;
	assign jumpSelect = (opcode == opJcond) & condMet;

endmodule

// ==== verilog/isaPkg.sv ====
package isaPkg;

	localparam int instWidth = 18;

	//////////////////////////////////////////////////
	// opcode values in the top six bits
	//////////////////////////////////////////////////

	// register form arithmetic and logic
	localparam logic [5:0] opAdd = 6'h01;
	localparam logic [5:0] opAddc = 6'h02;
	localparam logic [5:0] opSub = 6'h03;
	localparam logic [5:0] opAnd = 6'h04;
	localparam logic [5:0] opOr = 6'h05;
	localparam logic [5:0] opXor = 6'h06;
	localparam logic [5:0] opLsh = 6'h07;
	// compare is a subtract whose result is thrown away
	localparam logic [5:0] opCmp = 6'h08;
	// immediate form, the eight bit field is zero extended
	localparam logic [5:0] opAddi = 6'h10;
	localparam logic [5:0] opSubi = 6'h11;
	localparam logic [5:0] opMovi = 6'h12;
	// memory access through the address held in srcA
	localparam logic [5:0] opLoad = 6'h20;
	localparam logic [5:0] opStor = 6'h21;
	// relative jump, the condition sits in the dst field
	localparam logic [5:0] opJcond = 6'h30;

	// jump conditions, tested against the stored flags
	localparam logic [3:0] condAlways = 4'h0;
	localparam logic [3:0] condEq = 4'h1;
	localparam logic [3:0] condNe = 4'h2;
	localparam logic [3:0] condLo = 4'h3;

	// the same 18 bit word read either with two source registers or with an immediate
	typedef union packed {
		struct packed {logic [5:0] opcode; logic [3:0] dst; logic [3:0] srcA; logic [3:0] srcB;} regForm;
		struct packed {logic [5:0] opcode; logic [3:0] dst; logic [7:0] imm;} immForm;
	} instWord_u;

	typedef enum logic [3:0] {
		aluAdd, aluAddc, aluSub, aluAnd, aluOr, aluXor, aluShiftLeft, aluPassB
	} aluOp_e;

endpackage

// ==== verilog/progCounter.sv ====
`timescale 1ns/100ps

module progCounter import cpuPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic pcInc,
	input logic jumpSelect,
	input logic [7:0] offset,
	output logic [dataWidth-1:0] pc
);

	// step added to the PC, either one or the signed jump distance
	logic [dataWidth-1:0] step;

	// the offset is signed, so a negative value jumps backwards
	assign step = jumpSelect ? {{(dataWidth-8){offset[7]}}, offset} : dataWidth'(1);

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			pc <= '0;
		end else if (pcInc) begin
			// the jump is relative to the jump instruction itself
			pc <= pc + step;
		end
	end

	// wraps at the top of the 64k word space

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
	input logic CLK,
	input logic rstN,
	input logic load,
	input logic [3:0] loadReg,
	input logic [dataWidth-1:0] writeData,
	input logic [3:0] readRegA,
	input logic [3:0] readRegB,
	input logic [3:0] readRegM,
	output logic [dataWidth-1:0] regA,
	output logic [dataWidth-1:0] regB,
	output logic [dataWidth-1:0] regM
);

	logic [dataWidth-1:0] regs [regCount];
	// one bit per register, at most one of them high
	logic [regCount-1:0] writeEnable;

	assign writeEnable = load ? ({{(regCount-1){1'b0}}, 1'b1} << loadReg) : '0;

	// every register starts at zero, programs rely on it
	always_ff @(posedge CLK) begin
		for (int i = 0; i < regCount; i++) begin
			if (!rstN)
				regs[i] <= '0;
			else if (writeEnable[i])
				regs[i] <= writeData;
		end
	end

	// reads are asynchronous and see the old value until the edge
	assign regA = regs[readRegA];
	assign regB = regs[readRegB];
	assign regM = regs[readRegM];

endmodule
